// ==== common/soc_bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Processor bus widths and region codes
// Imported by the decoder, the word RAM and the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package soc_bus_pkg;

    // Byte address as issued by the processor
    typedef logic [31:0] addr_t;

    // One data word on the bus
    typedef logic [31:0] word_t;

    // One enable per byte lane
    typedef logic [3:0] wr_mask_t;

    // Top address nibble picks the region
    typedef logic [3:0] region_t;

    // Region 0 held the boot ROM and now counts as unmapped
    localparam region_t REGION_RAM    = 4'h1;
    localparam region_t REGION_PERIPH = 4'h2;

    // Inside region 2, address bits 15..12 pick a device page
    typedef logic [3:0] page_t;

    // Byte offset within one 4 kB page
    typedef logic [11:0] offset_t;

endpackage

// ==== common/soc_dev_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral register map, status bits and UART FSM states
// Imported by the peripheral registers, the UART and the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package soc_dev_pkg;

    // Data byte of UART, display and key codes
    typedef logic [7:0] byte_t;

    // Device pages inside region 2
    //   0x2000_1xxx display
    //   0x2000_2xxx UART data and status
    //   0x2000_5xxx PS/2 key FIFO status and code
    //   0x2000_6xxx SD card SPI pins
    localparam logic [3:0] PAGE_DISPLAY = 4'h1;
    localparam logic [3:0] PAGE_UART    = 4'h2;
    localparam logic [3:0] PAGE_KBD     = 4'h5;
    localparam logic [3:0] PAGE_SD      = 4'h6;

    // Register offsets within a page
    localparam logic [11:0] OFS_DATA   = 12'h000;
    localparam logic [11:0] OFS_STATUS = 12'h004;

    // UART status word
    localparam int UART_BUSY_BIT  = 0;
    localparam int UART_VALID_BIT = 1;

    // SD card register, write side
    localparam int SD_MOSI_BIT = 0;
    localparam int SD_CS_BIT   = 1;
    localparam int SD_SCLK_BIT = 2;

    // Shared by the transmitter and the receiver
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage

// ==== uart/uart_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8-N-1 UART with busy and valid flags
// Bit period is FREQ_HZ / BAUDS clock cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_core #(
    parameter int FREQ_HZ = 12_000_000,
    parameter int BAUDS   = 115_200
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               wr_i,
    input  logic               rd_i,
    input  soc_dev_pkg::byte_t tx_data_i,
    input  logic               rx_i,
    output logic               tx_o,
    output soc_dev_pkg::byte_t rx_data_o,
    output logic               busy_o,
    output logic               valid_o
);
    import soc_dev_pkg::*;

    localparam int DIV   = FREQ_HZ / BAUDS;
    localparam int CNT_W = $clog2(DIV);

    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(DIV - 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(DIV / 2 - 1);

    // Transmitter
    uart_state_e      tx_state;
    logic [CNT_W-1:0] tx_cnt;
    logic [2:0]       tx_bit;
    byte_t            tx_shift;
    logic             tx_tick;

    // Receiver
    logic             rx_meta;
    logic             rx_sync;
    uart_state_e      rx_state;
    logic [CNT_W-1:0] rx_cnt;
    logic [2:0]       rx_bit;
    byte_t            rx_shift;
    logic             rx_tick;

    assign tx_tick = tx_cnt == FULL_BIT;
    assign busy_o  = tx_state != UART_IDLE;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tx_state <= UART_IDLE;
            tx_cnt   <= '0;
            tx_bit   <= '0;
        end else begin
            tx_cnt <= (tx_state == UART_IDLE || tx_tick) ? '0 : tx_cnt + 1'b1;
            case (tx_state)
                UART_IDLE: begin
                    if (wr_i) begin
                        tx_state <= UART_START;
                    end
                end
                UART_START: begin
                    if (tx_tick) begin
                        tx_bit   <= '0;
                        tx_state <= UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (tx_tick) begin
                        tx_bit <= tx_bit + 1'b1;
                        if (tx_bit == 3'd7) begin
                            tx_state <= UART_STOP;
                        end
                    end
                end
                default: begin
                    if (tx_tick) begin
                        tx_state <= UART_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB goes out first
    always_ff @(posedge clk) begin
        if (tx_state == UART_IDLE && wr_i) begin
            tx_shift <= tx_data_i;
        end else if (tx_state == UART_DATA && tx_tick) begin
            tx_shift <= tx_shift >> 1;
        end
    end

    always_comb begin
        case (tx_state)
            UART_START: tx_o = 1'b0;
            UART_DATA:  tx_o = tx_shift[0];
            default:    tx_o = 1'b1;
        endcase
    end

    // Half a bit after the start edge, then one bit per sample
    assign rx_tick = (rx_state == UART_START) ? (rx_cnt == HALF_BIT) : (rx_cnt == FULL_BIT);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            rx_state <= UART_IDLE;
            rx_cnt   <= '0;
            rx_bit   <= '0;
            valid_o  <= 1'b0;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_cnt  <= (rx_state == UART_IDLE || rx_tick) ? '0 : rx_cnt + 1'b1;
            if (rd_i) begin
                valid_o <= 1'b0;
            end
            case (rx_state)
                UART_IDLE: begin
                    if (!rx_sync) begin
                        rx_state <= UART_START;
                    end
                end
                UART_START: begin
                    // A glitch shorter than half a bit is ignored
                    if (rx_tick) begin
                        rx_bit   <= '0;
                        rx_state <= rx_sync ? UART_IDLE : UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (rx_tick) begin
                        rx_bit <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= UART_STOP;
                        end
                    end
                end
                default: begin
                    if (rx_tick) begin
                        rx_state <= UART_IDLE;
                        if (rx_sync) begin
                            valid_o <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_state == UART_DATA && rx_tick) begin
            rx_shift <= {rx_sync, rx_shift[7:1]};
        end
        // Framing errors leave the last good byte in place
        if (rx_state == UART_STOP && rx_tick && rx_sync) begin
            rx_data_o <= rx_shift;
        end
    end

endmodule

// ==== logic/word_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port word RAM with byte lane writes
// Acknowledges one cycle after select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module word_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                  clk,
    input  logic                  sel_i,
    input  logic                  we_i,
    input  soc_bus_pkg::addr_t    addr_i,
    input  soc_bus_pkg::word_t    wdata_i,
    input  soc_bus_pkg::wr_mask_t wr_mask_i,
    output soc_bus_pkg::word_t    rdata_o,
    output logic                  ack_o
);
    import soc_bus_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    word_t            mem [RAM_WORDS];
    addr_t            word_addr;
    logic [IDX_W-1:0] idx;
    logic             access;

    assign word_addr = addr_i >> 2;
    assign idx       = IDX_W'(word_addr % RAM_WORDS);

    // Select is held through the ack cycle; act only once
    assign access = sel_i && !ack_o;

    always_ff @(posedge clk) begin
        ack_o <= access;
        if (access) begin
            if (we_i) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (wr_mask_i[lane]) begin
                        mem[idx][8*lane +: 8] <= wdata_i[8*lane +: 8];
                    end
                end
            end
            rdata_o <= mem[idx];
        end
    end

endmodule

// ==== logic/periph_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Region 2 registers for display, UART, PS/2 key FIFO and SD card pins
// Write and read strobes come from the bus decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module periph_regs #(
    parameter int KBD_FIFO_ADDR_BITS = 5
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               wr_i,
    input  logic               rd_i,
    input  soc_bus_pkg::addr_t addr_i,
    input  soc_bus_pkg::word_t wdata_i,
    output soc_bus_pkg::word_t rdata_o,
    output soc_dev_pkg::byte_t display_o,
    output logic               uart_wr_o,
    output logic               uart_rd_o,
    output soc_dev_pkg::byte_t uart_tx_data_o,
    input  soc_dev_pkg::byte_t uart_rx_data_i,
    input  logic               uart_busy_i,
    input  logic               uart_valid_i,
    input  soc_dev_pkg::byte_t kbd_code_i,
    input  logic               kbd_strobe_i,
    output logic               sd_csn_o,
    output logic               sd_sclk_o,
    output logic               sd_mosi_o,
    input  logic               sd_miso_i
);
    import soc_bus_pkg::*;
    import soc_dev_pkg::*;

    localparam int AW        = KBD_FIFO_ADDR_BITS;
    localparam int KBD_DEPTH = 2 ** AW;

    page_t   page;
    offset_t offset;
    logic    uart_data_wr;
    logic    kbd_deq_req;

    // Pointers carry one extra wrap bit
    byte_t       kbd_mem [KBD_DEPTH];
    logic [AW:0] kbd_wr_ptr;
    logic [AW:0] kbd_rd_ptr;
    logic        kbd_empty;
    logic        kbd_full;
    logic        kbd_push;
    byte_t       kbd_in_r;
    logic        kbd_deq;
    byte_t       kbd_code_r;

    assign page   = addr_i[15:12];
    assign offset = addr_i[11:0];

    assign uart_data_wr = wr_i && (page == PAGE_UART) && (offset == OFS_DATA);
    assign kbd_deq_req  = wr_i && (page == PAGE_KBD) && (offset == OFS_DATA);

    assign kbd_empty = kbd_wr_ptr == kbd_rd_ptr;
    assign kbd_full  = (kbd_wr_ptr[AW] != kbd_rd_ptr[AW]) &&
                       (kbd_wr_ptr[AW-1:0] == kbd_rd_ptr[AW-1:0]);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            display_o  <= '0;
            sd_sclk_o  <= 1'b0;
            sd_csn_o   <= 1'b1;
            sd_mosi_o  <= 1'b0;
            uart_wr_o  <= 1'b0;
            uart_rd_o  <= 1'b0;
            kbd_push   <= 1'b0;
            kbd_deq    <= 1'b0;
            kbd_wr_ptr <= '0;
            kbd_rd_ptr <= '0;
        end else begin
            uart_wr_o <= uart_data_wr;
            // Reading the data register consumes the received byte
            uart_rd_o <= rd_i && (page == PAGE_UART) && (offset == OFS_DATA);
            kbd_push  <= kbd_strobe_i;
            kbd_deq   <= kbd_deq_req && !kbd_empty;
            if (wr_i && page == PAGE_DISPLAY) begin
                display_o <= wdata_i[7:0];
            end
            if (wr_i && page == PAGE_SD && offset == OFS_DATA) begin
                sd_sclk_o <= wdata_i[SD_SCLK_BIT];
                sd_csn_o  <= ~wdata_i[SD_CS_BIT];
                sd_mosi_o <= wdata_i[SD_MOSI_BIT];
            end
            // Codes arriving while full are lost
            if (kbd_push && !kbd_full) begin
                kbd_wr_ptr <= kbd_wr_ptr + 1'b1;
            end
            if (kbd_deq) begin
                kbd_rd_ptr <= kbd_rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (uart_data_wr) begin
            uart_tx_data_o <= wdata_i[7:0];
        end
        if (kbd_strobe_i) begin
            kbd_in_r <= kbd_code_i;
        end
        if (kbd_push && !kbd_full) begin
            kbd_mem[kbd_wr_ptr[AW-1:0]] <= kbd_in_r;
        end
        // Head of FIFO moves into the code latch as it pops
        if (kbd_deq) begin
            kbd_code_r <= kbd_mem[kbd_rd_ptr[AW-1:0]];
        end
    end

    always_comb begin
        rdata_o = '0;
        case (page)
            PAGE_UART: begin
                if (offset == OFS_DATA) begin
                    rdata_o[7:0] = uart_rx_data_i;
                end else if (offset == OFS_STATUS) begin
                    rdata_o[UART_BUSY_BIT]  = uart_busy_i;
                    rdata_o[UART_VALID_BIT] = uart_valid_i;
                end
            end
            PAGE_KBD: begin
                // Status bit 0 flags a waiting key code
                if (offset == OFS_DATA) begin
                    rdata_o[0] = !kbd_empty;
                end else if (offset == OFS_STATUS) begin
                    rdata_o[7:0] = kbd_code_r;
                end
            end
            PAGE_SD: begin
                if (offset == OFS_DATA) begin
                    rdata_o[0] = sd_miso_i;
                end
            end
            default: begin
                rdata_o = '0;
            end
        endcase
    end

endmodule

// ==== logic/bus_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Region decode and acknowledge for the processor bus
// Halts for good on a select to an unmapped region
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bus_decoder (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               sel_i,
    input  soc_bus_pkg::addr_t addr_i,
    input  logic               we_i,
    input  logic               ram_ack_i,
    input  soc_bus_pkg::word_t ram_rdata_i,
    input  soc_bus_pkg::word_t periph_rdata_i,
    output logic               ram_sel_o,
    output logic               periph_wr_o,
    output logic               periph_rd_o,
    output soc_bus_pkg::word_t rdata_o,
    output logic               ack_o,
    output logic               halt_o
);
    import soc_bus_pkg::*;

    region_t region;
    logic    active;
    logic    dev_sel;
    logic    unmapped;
    logic    dev_ack;

    assign region = addr_i[31:28];

    // Nothing gets through once halted
    assign active   = sel_i && !halt_o;
    assign dev_sel  = active && (region == REGION_PERIPH);
    assign unmapped = (region != REGION_RAM) && (region != REGION_PERIPH);

    assign ram_sel_o = active && (region == REGION_RAM);

    // Device strobes only in the first cycle, before the ack
    assign periph_wr_o = dev_sel && !dev_ack && we_i;
    assign periph_rd_o = dev_sel && !dev_ack && !we_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dev_ack <= 1'b0;
            halt_o  <= 1'b0;
        end else begin
            // Select stays up during the ack cycle, so no second ack
            dev_ack <= dev_sel && !dev_ack;
            if (active && unmapped) begin
                halt_o <= 1'b1;
            end
        end
    end

    assign ack_o = ram_ack_i || dev_ack;

    // Peripheral data is combinational and valid while the ack is high
    assign rdata_o = (region == REGION_RAM) ? ram_rdata_i : periph_rdata_i;

endmodule

// ==== logic/soc_io_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory-mapped I/O side of the SoC, driven by a bus master
// Holds the decoder, the word RAM, the peripheral registers and the UART
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module soc_io_top #(
    parameter int FREQ_HZ            = 12_000_000,
    parameter int BAUDS              = 115_200,
    parameter int RAM_WORDS          = 1024,
    parameter int KBD_FIFO_ADDR_BITS = 5
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  sel_i,
    input  soc_bus_pkg::addr_t    addr_i,
    input  logic                  we_i,
    input  soc_bus_pkg::word_t    wdata_i,
    input  soc_bus_pkg::wr_mask_t wr_mask_i,
    output soc_bus_pkg::word_t    rdata_o,
    output logic                  ack_o,
    output logic                  halt_o,
    output soc_dev_pkg::byte_t    display_o,
    input  logic                  rx_i,
    output logic                  tx_o,
    input  soc_dev_pkg::byte_t    kbd_code_i,
    input  logic                  kbd_strobe_i,
    output logic                  sd_csn_o,
    output logic                  sd_sclk_o,
    output logic                  sd_mosi_o,
    input  logic                  sd_miso_i
);
    import soc_bus_pkg::*;
    import soc_dev_pkg::*;

    // RAM side
    logic  ram_sel;
    logic  ram_ack;
    word_t ram_rdata;

    // Peripheral side
    logic  periph_wr;
    logic  periph_rd;
    word_t periph_rdata;

    // UART strobes and flags
    logic  uart_wr;
    logic  uart_rd;
    byte_t uart_tx_data;
    byte_t uart_rx_data;
    logic  uart_busy;
    logic  uart_valid;

    bus_decoder u_bus_decoder (
        .clk            (clk),
        .reset_i        (reset_i),
        .sel_i          (sel_i),
        .addr_i         (addr_i),
        .we_i           (we_i),
        .ram_ack_i      (ram_ack),
        .ram_rdata_i    (ram_rdata),
        .periph_rdata_i (periph_rdata),
        .ram_sel_o      (ram_sel),
        .periph_wr_o    (periph_wr),
        .periph_rd_o    (periph_rd),
        .rdata_o        (rdata_o),
        .ack_o          (ack_o),
        .halt_o         (halt_o)
    );

    word_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_word_ram (
        .clk       (clk),
        .sel_i     (ram_sel),
        .we_i      (we_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .wr_mask_i (wr_mask_i),
        .rdata_o   (ram_rdata),
        .ack_o     (ram_ack)
    );

    periph_regs #(
        .KBD_FIFO_ADDR_BITS (KBD_FIFO_ADDR_BITS)
    ) u_periph_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .wr_i           (periph_wr),
        .rd_i           (periph_rd),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .rdata_o        (periph_rdata),
        .display_o      (display_o),
        .uart_wr_o      (uart_wr),
        .uart_rd_o      (uart_rd),
        .uart_tx_data_o (uart_tx_data),
        .uart_rx_data_i (uart_rx_data),
        .uart_busy_i    (uart_busy),
        .uart_valid_i   (uart_valid),
        .kbd_code_i     (kbd_code_i),
        .kbd_strobe_i   (kbd_strobe_i),
        .sd_csn_o       (sd_csn_o),
        .sd_sclk_o      (sd_sclk_o),
        .sd_mosi_o      (sd_mosi_o),
        .sd_miso_i      (sd_miso_i)
    );

    uart_core #(
        .FREQ_HZ (FREQ_HZ),
        .BAUDS   (BAUDS)
    ) u_uart_core (
        .clk       (clk),
        .reset_i   (reset_i),
        .wr_i      (uart_wr),
        .rd_i      (uart_rd),
        .tx_data_i (uart_tx_data),
        .rx_i      (rx_i),
        .tx_o      (tx_o),
        .rx_data_o (uart_rx_data),
        .busy_o    (uart_busy),
        .valid_o   (uart_valid)
    );

endmodule

// ==== dv/bus_decoder_props.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake and halt assertions for the bus decoder
// Bound into every bus_decoder instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bus_decoder_props (
    input logic clk,
    input logic reset_i,
    input logic ack_i,
    input logic halt_i
);

    // Acknowledge is a single-cycle pulse
    ack_one_cycle: assert property (
        @(posedge clk) disable iff (reset_i)
        ack_i |=> !ack_i
    ) else $error("ack_o stayed high for two cycles");

    // A halted bus never acknowledges
    no_ack_when_halted: assert property (
        @(posedge clk) disable iff (reset_i)
        halt_i |-> !$rose(ack_i)
    ) else $error("ack_o rose while halt_o was high");

    // Only reset releases the halt
    halt_sticky: assert property (
        @(posedge clk)
        (halt_i && !reset_i) |=> halt_i
    ) else $error("halt_o fell without reset");

endmodule

bind bus_decoder bus_decoder_props u_bus_decoder_props (
    .clk     (clk),
    .reset_i (reset_i),
    .ack_i   (ack_o),
    .halt_i  (halt_o)
);

// ==== dv/soc_io_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the SoC I/O side, acting as bus master
// Also drives PS/2 codes and the SD card MISO pin
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module soc_io_tb;
    import soc_bus_pkg::*;
    import soc_dev_pkg::*;

    localparam int ACK_TIMEOUT = 20;
    localparam int UART_POLLS  = 200;

    localparam addr_t DISPLAY_ADDR   = {REGION_PERIPH, 12'h000, PAGE_DISPLAY, OFS_DATA};
    localparam addr_t UART_DATA_ADDR = {REGION_PERIPH, 12'h000, PAGE_UART, OFS_DATA};
    localparam addr_t UART_STAT_ADDR = {REGION_PERIPH, 12'h000, PAGE_UART, OFS_STATUS};
    localparam addr_t KBD_STAT_ADDR  = {REGION_PERIPH, 12'h000, PAGE_KBD, OFS_DATA};
    localparam addr_t KBD_CODE_ADDR  = {REGION_PERIPH, 12'h000, PAGE_KBD, OFS_STATUS};
    localparam addr_t SD_ADDR        = {REGION_PERIPH, 12'h000, PAGE_SD, OFS_DATA};

    typedef enum {CHK_NONE, CHK_RDATA, CHK_DISPLAY, CHK_SD} chk_e;

    // One row of stimulus with its expected result
    typedef struct {
        logic     we;
        addr_t    addr;
        word_t    wdata;
        wr_mask_t mask;
        chk_e     chk;
        word_t    exp_val;
    } entry_t;

    logic     clk;
    logic     reset_i;
    logic     sel;
    addr_t    addr;
    logic     we;
    word_t    wdata;
    wr_mask_t wr_mask;
    word_t    rdata;
    logic     ack;
    logic     halt;
    byte_t    display;
    logic     tx_line;
    byte_t    kbd_code;
    logic     kbd_strobe;
    logic     sd_csn;
    logic     sd_sclk;
    logic     sd_mosi;
    logic     sd_miso;

    entry_t stim [$];
    int     errors;
    int     errors_before;
    int     tests_run;
    int     tests_failed;

    soc_io_top #(
        .FREQ_HZ            (250_000_000),
        .BAUDS              (25_000_000),
        .RAM_WORDS          (256),
        .KBD_FIFO_ADDR_BITS (2)
    ) u_soc_io_top (
        .clk          (clk),
        .reset_i      (reset_i),
        .sel_i        (sel),
        .addr_i       (addr),
        .we_i         (we),
        .wdata_i      (wdata),
        .wr_mask_i    (wr_mask),
        .rdata_o      (rdata),
        .ack_o        (ack),
        .halt_o       (halt),
        .display_o    (display),
        .rx_i         (tx_line),
        .tx_o         (tx_line),
        .kbd_code_i   (kbd_code),
        .kbd_strobe_i (kbd_strobe),
        .sd_csn_o     (sd_csn),
        .sd_sclk_o    (sd_sclk),
        .sd_mosi_o    (sd_mosi),
        .sd_miso_i    (sd_miso)
    );

    always #2 clk = ~clk;

    task automatic expect_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic verify_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic apply_reset();
        reset_i = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset_i = 1'b0;
    endtask

    // Holds select until ack or timeout, then leaves one idle cycle
    task automatic bus_access(input logic wr, input addr_t a, input word_t d,
                              input wr_mask_t m, output word_t rd,
                              output logic acked, output int cycles);
        sel     = 1'b1;
        addr    = a;
        we      = wr;
        wdata   = d;
        wr_mask = m;
        cycles  = 0;
        acked   = 1'b0;
        rd      = '0;
        while (!acked && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            acked = ack;
        end
        if (acked) begin
            rd = rdata;
        end
        sel = 1'b0;
        we  = 1'b0;
        @(posedge clk);
        #1;
    endtask

    // Access that must be acknowledged one cycle after select
    task automatic run_access(input logic wr, input addr_t a, input word_t d,
                              input wr_mask_t m, output word_t rd);
        logic acked;
        int   cycles;
        bus_access(wr, a, d, m, rd, acked, cycles);
        if (!acked) begin
            errors++;
            $display("Timeout at %0t ns: no acknowledge for address %h", $time, a);
        end else if (cycles != 1) begin
            errors++;
            $display("Late acknowledge at %0t ns: address %h took %0d cycles", $time, a, cycles);
        end
    endtask

    function automatic void add_entry(input logic wr, input addr_t a, input word_t d,
                                      input wr_mask_t m, input chk_e c, input word_t x);
        stim.push_back('{wr, a, d, m, c, x});
    endfunction

    // Old bytes survive wherever the mask bit is clear
    function automatic word_t merge_lanes(input word_t old_w, input word_t new_w,
                                          input wr_mask_t m);
        word_t res;
        res = old_w;
        for (int lane = 0; lane < 4; lane++) begin
            if (m[lane]) begin
                res[8*lane +: 8] = new_w[8*lane +: 8];
            end
        end
        return res;
    endfunction

    // Expected pins as {sclk, csn, mosi}
    function automatic word_t sd_pins(input word_t d);
        return {29'b0, d[SD_SCLK_BIT], ~d[SD_CS_BIT], d[SD_MOSI_BIT]};
    endfunction

    task automatic apply_entry(input entry_t e);
        word_t rd;
        run_access(e.we, e.addr, e.wdata, e.mask, rd);
        case (e.chk)
            CHK_RDATA: expect_word("rdata_o", rd, e.exp_val);
            CHK_DISPLAY: compare_byte("display_o", display, e.exp_val[7:0]);
            CHK_SD: begin
                verify_bit("sd_sclk_o", sd_sclk, e.exp_val[2]);
                verify_bit("sd_csn_o", sd_csn, e.exp_val[1]);
                verify_bit("sd_mosi_o", sd_mosi, e.exp_val[0]);
            end
            default: begin
            end
        endcase
    endtask

    task automatic run_table();
        foreach (stim[i]) begin
            apply_entry(stim[i]);
        end
        stim.delete();
    endtask

    task automatic push_key(input byte_t code);
        kbd_code   = code;
        kbd_strobe = 1'b1;
        @(posedge clk);
        #1;
        kbd_strobe = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("Test %-10s FAIL", name);
        end else begin
            $display("Test %-10s PASS", name);
        end
        errors_before = errors;
    endtask

    initial begin
        word_t    rd;
        word_t    wd;
        word_t    shadow;
        addr_t    a;
        logic     acked;
        int       cycles;
        int       polls;
        byte_t    keys [5];
        wr_mask_t masks [6];
        word_t    sd_vals [4];

        keys    = '{8'h1c, 8'h32, 8'h21, 8'h23, 8'h24};
        masks   = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0011, 4'b1100};
        sd_vals = '{32'h7, 32'h2, 32'h5, 32'h0};

        clk           = 1'b0;
        reset_i       = 1'b1;
        sel           = 1'b0;
        addr          = '0;
        we            = 1'b0;
        wdata         = '0;
        wr_mask       = '0;
        kbd_code      = '0;
        kbd_strobe    = 1'b0;
        sd_miso       = 1'b0;
        errors        = 0;
        errors_before = 0;
        tests_run     = 0;
        tests_failed  = 0;
        void'($urandom(32'h2026e50b));
        apply_reset();

        // RAM with full and partial byte masks
        for (int i = 0; i < 6; i++) begin
            a      = 32'h1000_0000 + addr_t'(i * 64);
            wd     = $urandom;
            shadow = wd;
            add_entry(1'b1, a, wd, 4'hf, CHK_NONE, '0);
            add_entry(1'b0, a, '0, 4'h0, CHK_RDATA, shadow);
            wd     = $urandom;
            shadow = merge_lanes(shadow, wd, masks[i]);
            add_entry(1'b1, a, wd, masks[i], CHK_NONE, '0);
            add_entry(1'b0, a, '0, 4'h0, CHK_RDATA, shadow);
        end
        run_table();
        end_test("ram");

        // Display and SD card pins
        add_entry(1'b1, DISPLAY_ADDR, 32'h0000_5ac3, 4'hf, CHK_DISPLAY, 32'h0000_00c3);
        add_entry(1'b1, DISPLAY_ADDR, 32'h1234_0017, 4'hf, CHK_DISPLAY, 32'h0000_0017);
        foreach (sd_vals[i]) begin
            add_entry(1'b1, SD_ADDR, sd_vals[i], 4'hf, CHK_SD, sd_pins(sd_vals[i]));
        end
        run_table();
        sd_miso = 1'b1;
        run_access(1'b0, SD_ADDR, '0, 4'h0, rd);
        expect_word("rdata_o", rd, 32'h1);
        sd_miso = 1'b0;
        run_access(1'b0, SD_ADDR, '0, 4'h0, rd);
        expect_word("rdata_o", rd, 32'h0);
        end_test("display_sd");

        // UART loopback through tx_o and rx_i
        run_access(1'b1, UART_DATA_ADDR, 32'h0000_00a5, 4'hf, rd);
        run_access(1'b0, UART_STAT_ADDR, '0, 4'h0, rd);
        verify_bit("uart status busy", rd[UART_BUSY_BIT], 1'b1);
        polls = 0;
        rd    = '0;
        while (!rd[UART_VALID_BIT] && polls < UART_POLLS) begin
            run_access(1'b0, UART_STAT_ADDR, '0, 4'h0, rd);
            polls++;
        end
        if (!rd[UART_VALID_BIT]) begin
            errors++;
            $display("Timeout at %0t ns: UART receiver never set valid", $time);
        end
        run_access(1'b0, UART_DATA_ADDR, '0, 4'h0, rd);
        compare_byte("uart rx data", rd[7:0], 8'ha5);
        run_access(1'b0, UART_STAT_ADDR, '0, 4'h0, rd);
        verify_bit("uart status valid", rd[UART_VALID_BIT], 1'b0);
        end_test("uart");

        // Fifth code finds the 4-entry FIFO full
        foreach (keys[i]) begin
            push_key(keys[i]);
        end
        repeat (3) @(posedge clk);
        #1;
        for (int i = 0; i < 4; i++) begin
            run_access(1'b0, KBD_STAT_ADDR, '0, 4'h0, rd);
            verify_bit("kbd status", rd[0], 1'b1);
            run_access(1'b1, KBD_STAT_ADDR, '0, 4'hf, rd);
            run_access(1'b0, KBD_CODE_ADDR, '0, 4'h0, rd);
            compare_byte("kbd code", rd[7:0], keys[i]);
        end
        run_access(1'b0, KBD_STAT_ADDR, '0, 4'h0, rd);
        verify_bit("kbd status", rd[0], 1'b0);
        end_test("keyboard");

        // Unmapped region 3 halts the bus
        bus_access(1'b0, 32'h3000_0000, '0, 4'h0, rd, acked, cycles);
        if (acked) begin
            errors++;
            $display("Unexpected acknowledge at %0t ns for unmapped region 3", $time);
        end
        verify_bit("halt_o", halt, 1'b1);
        bus_access(1'b0, 32'h1000_0000, '0, 4'h0, rd, acked, cycles);
        if (acked) begin
            errors++;
            $display("RAM access acknowledged at %0t ns while halted", $time);
        end
        apply_reset();
        verify_bit("halt_o", halt, 1'b0);
        end_test("halt");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
common/soc_bus_pkg.sv
common/soc_dev_pkg.sv
uart/uart_core.sv
logic/word_ram.sv
logic/periph_regs.sv
logic/bus_decoder.sv
logic/soc_io_top.sv
dv/bus_decoder_props.sv
dv/soc_io_tb.sv
